// File: rtl/cam_bist_pkg.sv
// Shared definitions for the CAM MBIST
//   Sizes and march patterns
//   Vector typedefs for addresses, words, match lines and counts
//   Enums for commands, match select and march phase
//   Packed structs passed between sequencer, CAM, handler, FIFO and checker
`default_nettype none

package cam_bist_pkg;

  // ==================================================
  // Sizes
  // ==================================================
  localparam int cam_entries    = 32;
  localparam int cam_width      = 16;
  localparam int cam_addr_w     = 5;
  localparam int fifo_depth     = 8;
  // Cycles from an accepted op to CAM output
  localparam int search_latency = 2;

  typedef logic [cam_addr_w-1:0]  cam_addr_t;
  typedef logic [cam_width-1:0]   cam_word_t;
  typedef logic [cam_entries-1:0] match_vec_t;
  typedef logic [7:0]             fail_cnt_t;

  // ==================================================
  // March patterns
  // ==================================================
  // Unique pattern of entry n: n in the low byte, ~n in the high byte
  // None of these ever equals the common, alternate or absent key
  localparam cam_word_t pat_common = 16'hA5A5;
  localparam cam_word_t pat_alt    = 16'h5A5A;
  localparam cam_word_t key_absent = 16'hFFFF;

  typedef enum logic [1:0] {
    cmd_write  = 2'd0,
    cmd_search = 2'd1,
    cmd_read   = 2'd2
  } cam_cmd_e;

  // Reference match vector selection
  typedef enum logic [1:0] {
    all_match       = 2'b00,
    single_match    = 2'b01,
    single_mismatch = 2'b10,
    all_mismatch    = 2'b11
  } match_sel_e;

  typedef enum logic [2:0] {
    phase_a = 3'd0,
    phase_d = 3'd1,
    phase_b = 3'd2,
    phase_r = 3'd3,
    phase_c = 3'd4
  } bist_phase_e;

  // ==================================================
  // Structs
  // ==================================================
  // One operation from sequencer to CAM, data is the key for a search
  typedef struct packed {
    cam_cmd_e    cmd;
    cam_addr_t   addr;
    cam_word_t   data;
    match_sel_e  msel;
    bist_phase_e phase;
    cam_word_t   exp;
    logic        last;
  } cam_op_t;

  // Handler's delayed copy of an op
  typedef struct packed {
    cam_addr_t   addr;
    match_sel_e  msel;
    bist_phase_e phase;
    logic        cmp_mode;
    cam_word_t   exp;
    logic        last;
  } cam_tag_t;

  typedef struct packed {
    cam_word_t   word;
    cam_word_t   exp;
    cam_addr_t   addr;
    bist_phase_e phase;
    logic        last;
  } cam_result_t;

  typedef struct packed {
    cam_addr_t   addr;
    bist_phase_e phase;
  } fail_rec_t;

  // Match line defect, entries past the last one select nothing
  typedef struct packed {
    logic       en;
    logic       stuck;
    logic [6:0] entry;
  } fault_cfg_t;

endpackage

`default_nettype wire

// File: rtl/cam_bist_sequencer.sv
// March sequencer for the CAM MBIST
//   Phase A: common pattern everywhere, all-match searches
//   Phase D: per entry alternate write, single-mismatch search, restore
//   Phase B: unique patterns, single-match searches
//   Phase R: read back, Phase C: absent key, all-mismatch searches
`timescale 1ns/1ps
`default_nettype none

module cam_bist_sequencer (
  input  logic                  bist_clk,
  input  logic                  rst_n,
  input  logic                  start,
  output logic                  op_valid,
  input  logic                  issue_ok,
  output cam_bist_pkg::cam_op_t op,
  output logic                  busy
);
  import cam_bist_pkg::*;

  bist_phase_e phase;
  // Sub-step: loop half in A and B, op within an entry in D
  logic [1:0]  step;
  cam_addr_t   addr;
  cam_word_t   uniq_pat;
  logic        last_addr;
  logic        advance;

  assign op_valid  = busy;
  assign advance   = busy && issue_ok;
  assign last_addr = (addr == cam_addr_t'(cam_entries - 1));
  // Address in low byte, inverse in high byte
  assign uniq_pat  = {~{3'b000, addr}, {3'b000, addr}};

  // ==================================================
  // Phase, step and address counters
  // ==================================================
  always_ff @(posedge bist_clk) begin
    if (!rst_n) begin
      busy  <= 1'b0;
      phase <= phase_a;
      step  <= '0;
      addr  <= '0;
    end else if (!busy) begin
      if (start) begin
        busy  <= 1'b1;
        phase <= phase_a;
        step  <= '0;
        addr  <= '0;
      end
    end else if (advance) begin
      case (phase)
        phase_a, phase_b: begin
          addr <= addr + cam_addr_t'(1);
          if (last_addr) begin
            // Writes done, now the searches
            if (step == 2'd0) begin
              step <= 2'd1;
            end else begin
              step  <= '0;
              phase <= (phase == phase_a) ? phase_d : phase_r;
            end
          end
        end
        phase_d: begin
          if (step == 2'd2) begin
            step <= '0;
            addr <= addr + cam_addr_t'(1);
            if (last_addr) begin
              phase <= phase_b;
            end
          end else begin
            step <= step + 2'd1;
          end
        end
        phase_r: begin
          addr <= addr + cam_addr_t'(1);
          if (last_addr) begin
            phase <= phase_c;
          end
        end
        default: begin
          addr <= addr + cam_addr_t'(1);
          // Final phase C search ends the march
          if (last_addr) begin
            busy <= 1'b0;
          end
        end
      endcase
    end
  end

  // ==================================================
  // Op decode from current position
  // ==================================================
  always_comb begin
    op       = '0;
    op.addr  = addr;
    op.phase = phase;
    op.cmd   = cmd_search;
    op.msel  = all_match;
    op.data  = pat_common;
    case (phase)
      phase_a: begin
        if (step == 2'd0) begin
          op.cmd = cmd_write;
        end
      end
      phase_d: begin
        case (step)
          2'd0: begin
            op.cmd  = cmd_write;
            op.data = pat_alt;
          end
          2'd1: op.msel = single_mismatch;
          // Restore the common pattern
          default: op.cmd = cmd_write;
        endcase
      end
      phase_b: begin
        op.data = uniq_pat;
        if (step == 2'd0) begin
          op.cmd = cmd_write;
        end else begin
          op.msel = single_match;
        end
      end
      phase_r: begin
        op.cmd = cmd_read;
        op.exp = uniq_pat;
      end
      default: begin
        op.data = key_absent;
        op.msel = all_mismatch;
        op.last = last_addr;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/cam_array.sv
// Behavioral binary CAM, 32 entries by 16 bits
//   Write at the handshake, search and read through two pipeline stages
//   Per-entry valid bits
//   Stuck-at defect on one match line of the search output
`timescale 1ns/1ps
`default_nettype none

module cam_array (
  input  logic                     bist_clk,
  input  logic                     rst_n,
  input  logic                     op_valid,
  input  cam_bist_pkg::cam_op_t    op,
  input  cam_bist_pkg::fault_cfg_t fault,
  output logic                     out_valid,
  output cam_bist_pkg::match_vec_t match,
  output cam_bist_pkg::cam_word_t  rd_data
);
  import cam_bist_pkg::*;

  cam_word_t              mem [cam_entries];
  logic [cam_entries-1:0] entry_vld;
  match_vec_t             hit;
  logic                   do_write;
  logic                   do_lookup;

  // Pipeline stages
  logic       s1_valid;
  logic       s2_valid;
  match_vec_t s1_match;
  match_vec_t s2_match;
  cam_word_t  s1_rd;
  cam_word_t  s2_rd;

  assign do_write  = op_valid && (op.cmd == cmd_write);
  assign do_lookup = op_valid && (op.cmd != cmd_write);

  // Compare key against every valid entry
  always_comb begin
    for (int i = 0; i < cam_entries; i++) begin
      hit[i] = entry_vld[i] && (mem[i] == op.data);
    end
  end

  always_ff @(posedge bist_clk) begin
    if (do_write) begin
      mem[op.addr] <= op.data;
    end
  end

  always_ff @(posedge bist_clk) begin
    if (!rst_n) begin
      entry_vld <= '0;
      s1_valid  <= 1'b0;
      s2_valid  <= 1'b0;
    end else begin
      if (do_write) begin
        entry_vld[op.addr] <= 1'b1;
      end
      s1_valid <= do_lookup;
      s2_valid <= s1_valid;
    end
  end

  // Payload stages carry both results, the handler picks one
  always_ff @(posedge bist_clk) begin
    s1_match <= hit;
    s1_rd    <= mem[op.addr];
    s2_match <= s1_match;
    s2_rd    <= s1_rd;
  end

  assign out_valid = s2_valid;
  assign rd_data   = s2_rd;

  // Defect injection on the selected match line
  always_comb begin
    match = s2_match;
    if (fault.en && (fault.entry < 7'(cam_entries))) begin
      match[fault.entry[cam_addr_w-1:0]] = fault.stuck;
    end
  end

endmodule

`default_nettype wire

// File: rtl/cam_bist_outhandler.sv
// CAM MBIST output handler
//   Two-cycle delay of the op tag, matching the CAM latency
//   Expected match vector from match select and delayed address
//   Match compare, 32 to 16 compaction, compare/read output mux
`timescale 1ns/1ps
`default_nettype none

module cam_bist_outhandler (
  input  logic                      bist_clk,
  input  logic                      rst_n,
  input  logic                      op_valid,
  input  cam_bist_pkg::cam_op_t     op,
  input  logic                      out_valid,
  input  cam_bist_pkg::match_vec_t  match,
  input  cam_bist_pkg::cam_word_t   rd_data,
  output logic                      res_valid,
  output cam_bist_pkg::cam_result_t res
);
  import cam_bist_pkg::*;

  cam_tag_t   tag_in;
  cam_tag_t   tag_1d;
  cam_tag_t   tag_2d;
  logic       vld_1d;
  logic       vld_2d;
  match_vec_t ref_vec;
  match_vec_t single_vec;
  match_vec_t cmp_vec;
  cam_word_t  cmp_word;

  // ==================================================
  // Tag delay line
  // ==================================================
  always_comb begin
    tag_in.addr     = op.addr;
    tag_in.msel     = op.msel;
    tag_in.phase    = op.phase;
    tag_in.cmp_mode = (op.cmd == cmd_search);
    tag_in.exp      = op.exp;
    tag_in.last     = op.last;
  end

  // Only ops that produce CAM output are tracked
  always_ff @(posedge bist_clk) begin
    if (!rst_n) begin
      vld_1d <= 1'b0;
      vld_2d <= 1'b0;
    end else begin
      vld_1d <= op_valid && (op.cmd != cmd_write);
      vld_2d <= vld_1d;
    end
  end

  always_ff @(posedge bist_clk) begin
    if (op_valid) begin
      tag_1d <= tag_in;
    end
    tag_2d <= tag_1d;
  end

  // ==================================================
  // Reference vector and compare
  // ==================================================
  assign single_vec = match_vec_t'(1) << tag_2d.addr;

  always_comb begin
    case (tag_2d.msel)
      all_match:       ref_vec = '1;
      single_match:    ref_vec = single_vec;
      single_mismatch: ref_vec = ~single_vec;
      default:         ref_vec = '0;
    endcase
  end

  // A set bit marks a wrong match line
  assign cmp_vec = ref_vec ^ match;

  // Entries i and i+16 share one result bit
  assign cmp_word = cmp_vec[cam_width-1:0] | cmp_vec[cam_entries-1:cam_width];

  // ==================================================
  // Output mux
  // ==================================================
  assign res_valid = out_valid && vld_2d;

  always_comb begin
    res.addr  = tag_2d.addr;
    res.phase = tag_2d.phase;
    res.last  = tag_2d.last;
    if (tag_2d.cmp_mode) begin
      res.word = cmp_word;
      res.exp  = '0;
    end else begin
      res.word = rd_data;
      res.exp  = tag_2d.exp;
    end
  end

endmodule

`default_nettype wire

// File: rtl/cam_result_fifo.sv
// Result FIFO between output handler and checker
//   8-slot circular buffer with occupancy count
//   Issue permission for the sequencer from free slots
`timescale 1ns/1ps
`default_nettype none

module cam_result_fifo (
  input  logic                      bist_clk,
  input  logic                      rst_n,
  input  logic                      in_valid,
  input  cam_bist_pkg::cam_result_t in_data,
  output logic                      issue_ok,
  output logic                      out_valid,
  input  logic                      out_ready,
  output cam_bist_pkg::cam_result_t out_data
);
  import cam_bist_pkg::*;

  localparam int ptr_w = $clog2(fifo_depth);

  cam_result_t      slots [fifo_depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [ptr_w:0]   count;
  logic             push;
  logic             pop;

  assign push      = in_valid;
  assign pop       = out_valid && out_ready;
  assign out_valid = (count != '0);
  assign out_data  = slots[rd_ptr];

  // Room for this op plus the ones still inside the CAM pipeline
  assign issue_ok = ((ptr_w+1)'(fifo_depth) - count) >= (ptr_w+1)'(search_latency + 1);

  always_ff @(posedge bist_clk) begin
    if (push) begin
      slots[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge bist_clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + ptr_w'(1);
      end
      if (pop) begin
        rd_ptr <= rd_ptr + ptr_w'(1);
      end
      case ({push, pop})
        2'b10:   count <= count + (ptr_w+1)'(1);
        2'b01:   count <= count - (ptr_w+1)'(1);
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: rtl/cam_bist_checker.sv
// MBIST result checker
//   Word against expected word compare per popped result
//   Fail count and first failing address/phase
//   Fail record output with hold until accepted, and done flag
`timescale 1ns/1ps
`default_nettype none

module cam_bist_checker (
  input  logic                      bist_clk,
  input  logic                      rst_n,
  input  logic                      start,
  input  logic                      in_valid,
  output logic                      in_ready,
  input  cam_bist_pkg::cam_result_t in_data,
  output logic                      fail_valid,
  input  logic                      fail_ready,
  output cam_bist_pkg::fail_rec_t   fail_rec,
  output cam_bist_pkg::fail_cnt_t   fail_count,
  output cam_bist_pkg::fail_rec_t   first_fail,
  output logic                      done
);
  import cam_bist_pkg::*;

  logic      pop;
  logic      mismatch;
  logic      first_seen;
  logic      last_seen;
  fail_rec_t cur_rec;

  // Stall the FIFO while a record waits
  assign in_ready = !fail_valid;
  assign pop      = in_valid && in_ready;
  assign mismatch = (in_data.word != in_data.exp);

  assign cur_rec.addr  = in_data.addr;
  assign cur_rec.phase = in_data.phase;

  always_ff @(posedge bist_clk) begin
    if (!rst_n || start) begin
      fail_valid <= 1'b0;
      fail_count <= '0;
      first_fail <= '0;
      first_seen <= 1'b0;
      last_seen  <= 1'b0;
      done       <= 1'b0;
    end else begin
      if (fail_valid && fail_ready) begin
        fail_valid <= 1'b0;
      end
      if (pop) begin
        if (mismatch) begin
          fail_valid <= 1'b1;
          fail_count <= fail_count + fail_cnt_t'(1);
          if (!first_seen) begin
            first_fail <= cur_rec;
            first_seen <= 1'b1;
          end
        end
        if (in_data.last) begin
          last_seen <= 1'b1;
        end
      end
      // Done once the last record has left
      if (last_seen && !fail_valid) begin
        done <= 1'b1;
      end
    end
  end

  // Record payload
  always_ff @(posedge bist_clk) begin
    if (pop && mismatch) begin
      fail_rec <= cur_rec;
    end
  end

endmodule

`default_nettype wire

// File: rtl/cam_bist_top.sv
// CAM MBIST top level
//   Sequencer, behavioral CAM, output handler, result FIFO, checker
//   Op handshake from sequencer valid and FIFO issue permission
`timescale 1ns/1ps
`default_nettype none

module cam_bist_top (
  input  logic                     bist_clk,
  input  logic                     rst_n,
  input  logic                     start,
  input  cam_bist_pkg::fault_cfg_t fault,
  output logic                     fail_valid,
  input  logic                     fail_ready,
  output cam_bist_pkg::fail_rec_t  fail_rec,
  output cam_bist_pkg::fail_cnt_t  fail_count,
  output cam_bist_pkg::fail_rec_t  first_fail,
  output logic                     done
);
  import cam_bist_pkg::*;

  logic        op_valid;
  logic        issue_ok;
  logic        op_fire;
  cam_op_t     op;
  logic        seq_busy;
  logic        chk_start;
  logic        cam_valid;
  match_vec_t  cam_match;
  cam_word_t   cam_rd_data;
  logic        res_valid;
  cam_result_t res;
  logic        fifo_valid;
  logic        fifo_ready;
  cam_result_t fifo_data;

  // Op accepted when the FIFO has room for it
  assign op_fire   = op_valid && issue_ok;
  // A start during a run is ignored everywhere
  assign chk_start = start && !seq_busy;

  cam_bist_sequencer u_seq (
    .bist_clk (bist_clk),
    .rst_n    (rst_n),
    .start    (start),
    .op_valid (op_valid),
    .issue_ok (issue_ok),
    .op       (op),
    .busy     (seq_busy)
  );

  cam_array u_cam (
    .bist_clk  (bist_clk),
    .rst_n     (rst_n),
    .op_valid  (op_fire),
    .op        (op),
    .fault     (fault),
    .out_valid (cam_valid),
    .match     (cam_match),
    .rd_data   (cam_rd_data)
  );

  cam_bist_outhandler u_oh (
    .bist_clk  (bist_clk),
    .rst_n     (rst_n),
    .op_valid  (op_fire),
    .op        (op),
    .out_valid (cam_valid),
    .match     (cam_match),
    .rd_data   (cam_rd_data),
    .res_valid (res_valid),
    .res       (res)
  );

  cam_result_fifo u_fifo (
    .bist_clk  (bist_clk),
    .rst_n     (rst_n),
    .in_valid  (res_valid),
    .in_data   (res),
    .issue_ok  (issue_ok),
    .out_valid (fifo_valid),
    .out_ready (fifo_ready),
    .out_data  (fifo_data)
  );

  cam_bist_checker u_chk (
    .bist_clk   (bist_clk),
    .rst_n      (rst_n),
    .start      (chk_start),
    .in_valid   (fifo_valid),
    .in_ready   (fifo_ready),
    .in_data    (fifo_data),
    .fail_valid (fail_valid),
    .fail_ready (fail_ready),
    .fail_rec   (fail_rec),
    .fail_count (fail_count),
    .first_fail (first_fail),
    .done       (done)
  );

endmodule

`default_nettype wire

// File: tests/tb_cam_bist.sv
// Table-driven testbench for the CAM MBIST top level
//   Clock, reset and start/fault stimulus per table row
//   Random back-pressure on the fail record port
//   Fail record monitor and expected fail list from the march rules
//   Count, first failure, record order and compaction checks
`timescale 1ns/1ps
`default_nettype none

module tb_cam_bist;
  import cam_bist_pkg::*;

  localparam int num_runs      = 8;
  localparam int done_timeout  = 5000;
  localparam int reset_cycles  = 8;

  // One table row: fault setting and expected summary
  typedef struct packed {
    fault_cfg_t fault;
    fail_cnt_t  exp_count;
    fail_rec_t  exp_first;
  } run_row_t;

  logic       bist_clk;
  logic       rst_n;
  logic       start;
  fault_cfg_t fault;
  logic       fail_valid;
  logic       fail_ready;
  fail_rec_t  fail_rec;
  fail_cnt_t  fail_count;
  fail_rec_t  first_fail;
  logic       done;

  run_row_t   runs [num_runs];
  int         counts [num_runs];
  fail_rec_t  got_q [$];
  fail_rec_t  exp_q [$];
  integer     seed = 32'h9f6f;
  int         checks = 0;
  int         errors = 0;

  cam_bist_top uut (
    .bist_clk   (bist_clk),
    .rst_n      (rst_n),
    .start      (start),
    .fault      (fault),
    .fail_valid (fail_valid),
    .fail_ready (fail_ready),
    .fail_rec   (fail_rec),
    .fail_count (fail_count),
    .first_fail (first_fail),
    .done       (done)
  );

  // ==================================================
  // Clock, back-pressure and record monitor
  // ==================================================
  initial begin
    bist_clk = 1'b0;
    forever #50 bist_clk = ~bist_clk;
  end

  // Ready low about one cycle in four
  always @(posedge bist_clk) begin
    fail_ready <= (($random(seed) & 3) != 0);
  end

  // Handshake seen at negedge completes at the next rising edge
  always @(negedge bist_clk) begin
    if (rst_n && fail_valid && fail_ready) begin
      got_q.push_back(fail_rec);
    end
  end

  // ==================================================
  // Helpers
  // ==================================================
  task automatic verify(input bit ok, input string what);
    checks++;
    assert (ok) else begin
      errors++;
      $display("CHECK FAILED at %0t: %s", $time, what);
    end
  endtask

  function automatic fail_rec_t make_rec(input int addr, input bist_phase_e phase);
    fail_rec_t r;
    r.addr  = cam_addr_t'(addr);
    r.phase = phase;
    return r;
  endfunction

  function automatic run_row_t make_row(input bit en, input bit stuck, input int entry,
                                        input int cnt, input int faddr,
                                        input bist_phase_e fphase);
    run_row_t row;
    row.fault.en    = en;
    row.fault.stuck = stuck;
    row.fault.entry = 7'(entry);
    row.exp_count   = fail_cnt_t'(cnt);
    row.exp_first   = make_rec(faddr, fphase);
    return row;
  endfunction

  // Rows with no failure expect a cleared first_fail
  task automatic load_table;
    runs[0] = make_row(1'b0, 1'b0, 0, 0, 0, phase_a);
    runs[1] = make_row(1'b1, 1'b1, 3, 64, 3, phase_d);
    runs[2] = make_row(1'b1, 1'b1, 19, 64, 19, phase_d);
    runs[3] = make_row(1'b1, 1'b0, 3, 64, 0, phase_a);
    runs[4] = make_row(1'b1, 1'b0, 19, 64, 0, phase_a);
    runs[5] = make_row(1'b1, 1'b1, 31, 64, 31, phase_d);
    // Disabled fault, then an entry past the array
    runs[6] = make_row(1'b0, 1'b1, 5, 0, 0, phase_a);
    runs[7] = make_row(1'b1, 1'b0, 40, 0, 0, phase_a);
  endtask

  // Fail records in issue order for a stuck match line on entry k
  task automatic build_expected(input fault_cfg_t f);
    int k;
    int a;
    exp_q.delete();
    if (!f.en || (f.entry >= 7'(cam_entries))) begin
      return;
    end
    k = int'(f.entry);
    if (f.stuck) begin
      // Extra hit where a mismatch or no match is expected
      exp_q.push_back(make_rec(k, phase_d));
      for (a = 0; a < cam_entries; a++) begin
        if (a != k) begin
          exp_q.push_back(make_rec(a, phase_b));
        end
      end
      for (a = 0; a < cam_entries; a++) begin
        exp_q.push_back(make_rec(a, phase_c));
      end
    end else begin
      // Missing hit wherever entry k should match
      for (a = 0; a < cam_entries; a++) begin
        exp_q.push_back(make_rec(a, phase_a));
      end
      for (a = 0; a < cam_entries; a++) begin
        if (a != k) begin
          exp_q.push_back(make_rec(a, phase_d));
        end
      end
      exp_q.push_back(make_rec(k, phase_b));
    end
  endtask

  // Apply one row, pulse start and wait for done
  task automatic run_march(input int row, output bit ok);
    int cycles;
    @(posedge bist_clk);
    fault <= runs[row].fault;
    got_q.delete();
    @(posedge bist_clk);
    start <= 1'b1;
    @(posedge bist_clk);
    start <= 1'b0;
    cycles = 0;
    @(negedge bist_clk);
    while (!done && (cycles < done_timeout)) begin
      @(negedge bist_clk);
      cycles++;
    end
    ok = done;
  endtask

  task automatic check_run(input int row);
    int n;
    build_expected(runs[row].fault);
    counts[row] = int'(fail_count);
    verify(fail_count == runs[row].exp_count,
           $sformatf("run %0d fail_count %0d, expected %0d", row, fail_count,
                     runs[row].exp_count));
    verify(first_fail == runs[row].exp_first,
           $sformatf("run %0d first_fail %0d/%s, expected %0d/%s", row, first_fail.addr,
                     first_fail.phase.name(), runs[row].exp_first.addr,
                     runs[row].exp_first.phase.name()));
    verify(!fail_valid, $sformatf("run %0d record still pending at done", row));
    verify(got_q.size() == int'(fail_count),
           $sformatf("run %0d got %0d records, fail_count %0d", row, got_q.size(),
                     fail_count));
    verify(got_q.size() == exp_q.size(),
           $sformatf("run %0d got %0d records, expected %0d", row, got_q.size(),
                     exp_q.size()));
    n = (got_q.size() < exp_q.size()) ? got_q.size() : exp_q.size();
    for (int i = 0; i < n; i++) begin
      verify(got_q[i] == exp_q[i],
             $sformatf("run %0d record %0d is %0d/%s, expected %0d/%s", row, i,
                       got_q[i].addr, got_q[i].phase.name(), exp_q[i].addr,
                       exp_q[i].phase.name()));
    end
  endtask

  task automatic report_and_finish;
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  endtask

  // ==================================================
  // Main sequence
  // ==================================================
  initial begin
    bit ok;
    bit timed_out;
    rst_n      = 1'b0;
    start      = 1'b0;
    fault      = '0;
    fail_ready = 1'b0;
    timed_out  = 1'b0;
    load_table();
    repeat (reset_cycles) @(posedge bist_clk);
    rst_n <= 1'b1;
    @(negedge bist_clk);
    verify(!done && !fail_valid && (fail_count == '0), "outputs not idle after reset");

    // Back-to-back runs, each start clears the previous summary
    for (int r = 0; r < num_runs; r++) begin
      run_march(r, ok);
      if (!ok) begin
        errors++;
        timed_out = 1'b1;
        $display("Timeout: done did not rise within %0d cycles on run %0d", done_timeout, r);
        break;
      end
      check_run(r);
    end

    // Entries k and k+16 share a compacted bit
    if (!timed_out) begin
      verify(counts[1] == counts[2], "stuck-at-1 counts differ between entries 3 and 19");
      verify(counts[3] == counts[4], "stuck-at-0 counts differ between entries 3 and 19");
    end
    report_and_finish();
  end

endmodule

`default_nettype wire

// File: build.f
rtl/cam_bist_pkg.sv
rtl/cam_bist_sequencer.sv
rtl/cam_array.sv
rtl/cam_bist_outhandler.sv
rtl/cam_result_fifo.sv
rtl/cam_bist_checker.sv
rtl/cam_bist_top.sv
tests/tb_cam_bist.sv

// File: Makefile
# Verilator build and run for the CAM MBIST testbench

SRCS := $(wildcard rtl/*.sv) $(wildcard tests/*.sv)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
obj_dir/Vtb_cam_bist: build.f $(SRCS)
	verilator --binary --timing -j 0 --top-module tb_cam_bist -f build.f

# Pass or fail comes from the log
run: obj_dir/Vtb_cam_bist
	./obj_dir/Vtb_cam_bist | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
